// ==== Bender.yml ====
package:
  name: mul_unit

export_include_dirs:
  - include

sources:
  - files:
      - logic/mul_pkg.sv
      - logic/mul_operand_prep.sv
      - logic/mul_req_fifo.sv
      - logic/mul_shift_add.sv
      - logic/mul_execute.sv
      - logic/mul_unit.sv
  - target: test
    files:
      - testbench/mul_unit_tb.sv

// ==== build.f ====
+incdir+include
logic/mul_pkg.sv
logic/mul_operand_prep.sv
logic/mul_req_fifo.sv
logic/mul_shift_add.sv
logic/mul_execute.sv
logic/mul_unit.sv
testbench/mul_unit_tb.sv

// ==== include/mul_defines.svh ====
`ifndef MUL_DEFINES_SVH
`define MUL_DEFINES_SVH

`define MUL_XLEN        32
`define MUL_TAG_W       4
`define MUL_FIFO_DEPTH  4

// low bits of funct3.
`define MUL_OP_MUL      2'd0
`define MUL_OP_MULH     2'd1
`define MUL_OP_MULHSU   2'd2
`define MUL_OP_MULHU    2'd3

`endif

// ==== logic/mul_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mul_defines.svh"

module mul_execute
    import mul_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      q_valid,
    input  mul_prep_t q,
    output logic      q_ready,
    output logic      start,
    output xlen_t     mag_a,
    output xlen_t     mag_b,
    input  logic      core_ready,
    input  logic      core_valid,
    input  dword_t    product,
    output logic      resp_valid,
    output mul_resp_t resp,
    input  logic      resp_ready
);

    exec_state_e state;
    logic        negate_r;
    logic        take_high_r;
    tag_t        tag_r;
    dword_t      fixed;

    // pop and start together.
    assign start   = (state == EXEC_IDLE) && q_valid && core_ready;
    assign q_ready = start;
    assign mag_a   = q.mag_a;
    assign mag_b   = q.mag_b;

    assign fixed      = negate_r ? dword_t'(-product) : product;
    assign resp_valid = (state == EXEC_HOLD);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= EXEC_IDLE;
        end else begin
            case (state)
                EXEC_IDLE: begin
                    if (start) begin
                        state <= EXEC_BUSY;
                    end
                end
                EXEC_BUSY: begin
                    if (core_valid) begin
                        state <= EXEC_HOLD;
                    end
                end
                EXEC_HOLD: begin
                    if (resp_ready) begin
                        state <= EXEC_IDLE;
                    end
                end
                default: state <= EXEC_IDLE;
            endcase
        end
    end

    // side info of the item in the core.
    always_ff @(posedge clk) begin
        if (start) begin
            negate_r    <= q.negate;
            take_high_r <= q.take_high;
            tag_r       <= q.tag;
        end
    end

    always_ff @(posedge clk) begin
        if (state == EXEC_BUSY && core_valid) begin
            if (take_high_r) begin
                resp.result <= fixed[2*`MUL_XLEN-1:`MUL_XLEN];
            end else begin
                resp.result <= fixed[`MUL_XLEN-1:0];
            end
            resp.tag <= tag_r;
        end
    end

endmodule

`default_nettype wire

// ==== logic/mul_operand_prep.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mul_defines.svh"

module mul_operand_prep
    import mul_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req_valid,
    input  mul_req_t  req,
    output logic      req_ready,
    output logic      prep_valid,
    output mul_prep_t prep,
    input  logic      prep_ready
);

    logic      signed_a;
    logic      signed_b;
    logic      neg_a;
    logic      neg_b;
    mul_prep_t prep_next;

    always_comb begin
        signed_a = 1'b0;
        signed_b = 1'b0;
        case (req.op)
            `MUL_OP_MUL: begin
                signed_a = 1'b0; // low word is sign independent.
                signed_b = 1'b0;
            end
            `MUL_OP_MULH: begin
                signed_a = 1'b1;
                signed_b = 1'b1;
            end
            `MUL_OP_MULHSU: begin
                signed_a = 1'b1;
                signed_b = 1'b0;
            end
            `MUL_OP_MULHU: begin
                signed_a = 1'b0;
                signed_b = 1'b0;
            end
            default: ;
        endcase
    end

    assign neg_a = signed_a & req.rs1[`MUL_XLEN-1];
    assign neg_b = signed_b & req.rs2[`MUL_XLEN-1];

    always_comb begin
        prep_next.mag_a     = neg_a ? xlen_t'(-req.rs1) : req.rs1;
        prep_next.mag_b     = neg_b ? xlen_t'(-req.rs2) : req.rs2;
        prep_next.negate    = neg_a ^ neg_b;
        prep_next.take_high = (req.op != `MUL_OP_MUL);
        prep_next.tag       = req.tag;
    end

    assign req_ready = !prep_valid || prep_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prep_valid <= 1'b0;
        end else if (req_ready) begin
            prep_valid <= req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            prep <= prep_next;
        end
    end

endmodule

`default_nettype wire

// ==== logic/mul_pkg.sv ====
`default_nettype none

`include "mul_defines.svh"

package mul_pkg;

    typedef logic [`MUL_XLEN-1:0]   xlen_t;
    typedef logic [2*`MUL_XLEN-1:0] dword_t;
    typedef logic [`MUL_TAG_W-1:0]  tag_t;
    typedef logic [1:0]             mul_op_t;

    typedef struct packed {
        mul_op_t op;
        xlen_t   rs1;
        xlen_t   rs2;
        tag_t    tag;
    } mul_req_t;

    // operands as magnitudes, sign fixed up after the core.
    typedef struct packed {
        xlen_t mag_a;
        xlen_t mag_b;
        logic  negate;
        logic  take_high;
        tag_t  tag;
    } mul_prep_t;

    typedef struct packed {
        xlen_t result;
        tag_t  tag;
    } mul_resp_t;

    typedef enum logic [1:0] {
        SHIFT_IDLE,
        SHIFT_MULT,
        SHIFT_DONE
    } shift_state_e;

    typedef enum logic [1:0] {
        EXEC_IDLE,
        EXEC_BUSY,
        EXEC_HOLD
    } exec_state_e;

endpackage

`default_nettype wire

// ==== logic/mul_req_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mul_defines.svh"

module mul_req_fifo
    import mul_pkg::*;
#(
    parameter int DEPTH = `MUL_FIFO_DEPTH
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      prep_valid,
    input  mul_prep_t prep,
    output logic      prep_ready,
    output logic      q_valid,
    output mul_prep_t q,
    input  logic      q_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    mul_prep_t        mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign prep_ready = (count != CNT_W'(DEPTH));
    assign q_valid    = (count != '0);
    assign q          = mem[rd_ptr];

    assign push = prep_valid && prep_ready;
    assign pop  = q_valid && q_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= prep;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                if (wr_ptr == PTR_W'(DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + PTR_W'(1);
                end
            end
            if (pop) begin
                if (rd_ptr == PTR_W'(DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + PTR_W'(1);
                end
            end
            case ({push, pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count; // both or neither.
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/mul_shift_add.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mul_defines.svh"

module mul_shift_add
    import mul_pkg::*;
#(
    parameter int WIDTH = `MUL_XLEN
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start,
    output logic               ready,
    output logic               valid,
    input  logic [WIDTH-1:0]   multiplicand,
    input  logic [WIDTH-1:0]   multiplier,
    output logic [2*WIDTH-1:0] product
);

    localparam int CNT_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    shift_state_e       state;
    logic [CNT_W-1:0]   count;
    logic [2*WIDTH-1:0] mcand; // shifts left each step.
    logic [WIDTH-1:0]   mplier;

    assign ready = (state == SHIFT_IDLE);
    assign valid = (state == SHIFT_DONE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= SHIFT_IDLE;
            count <= '0;
        end else begin
            case (state)
                SHIFT_IDLE: begin
                    if (start) begin
                        state <= SHIFT_MULT;
                        count <= '0;
                    end
                end
                SHIFT_MULT: begin
                    if (count == CNT_W'(WIDTH - 1)) begin
                        state <= SHIFT_DONE;
                    end
                    count <= count + CNT_W'(1);
                end
                SHIFT_DONE: state <= SHIFT_IDLE;
                default:    state <= SHIFT_IDLE;
            endcase
        end
    end

    // datapath, one multiplier bit per cycle.
    always_ff @(posedge clk) begin
        case (state)
            SHIFT_IDLE: begin
                if (start) begin
                    mcand   <= {{WIDTH{1'b0}}, multiplicand};
                    mplier  <= multiplier;
                    product <= '0;
                end
            end
            SHIFT_MULT: begin
                if (mplier[0]) begin
                    product <= product + mcand;
                end
                mcand  <= mcand << 1;
                mplier <= mplier >> 1;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/mul_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mul_defines.svh"

module mul_unit
    import mul_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req_valid,
    input  mul_req_t  req,
    output logic      req_ready,
    output logic      resp_valid,
    output mul_resp_t resp,
    input  logic      resp_ready
);

    logic      prep_valid;
    mul_prep_t prep;
    logic      prep_ready;
    logic      q_valid;
    mul_prep_t q;
    logic      q_ready;
    logic      start;
    xlen_t     mag_a;
    xlen_t     mag_b;
    logic      core_ready;
    logic      core_valid;
    dword_t    product;

    mul_operand_prep i_mul_operand_prep (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .prep_valid (prep_valid),
        .prep       (prep),
        .prep_ready (prep_ready)
    );

    mul_req_fifo #(
        .DEPTH (`MUL_FIFO_DEPTH)
    ) i_mul_req_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .prep_valid (prep_valid),
        .prep       (prep),
        .prep_ready (prep_ready),
        .q_valid    (q_valid),
        .q          (q),
        .q_ready    (q_ready)
    );

    mul_execute i_mul_execute (
        .clk        (clk),
        .rst_n      (rst_n),
        .q_valid    (q_valid),
        .q          (q),
        .q_ready    (q_ready),
        .start      (start),
        .mag_a      (mag_a),
        .mag_b      (mag_b),
        .core_ready (core_ready),
        .core_valid (core_valid),
        .product    (product),
        .resp_valid (resp_valid),
        .resp       (resp),
        .resp_ready (resp_ready)
    );

    mul_shift_add #(
        .WIDTH (`MUL_XLEN)
    ) i_mul_shift_add (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .ready        (core_ready),
        .valid        (core_valid),
        .multiplicand (mag_a),
        .multiplier   (mag_b),
        .product      (product)
    );

endmodule

`default_nettype wire

// ==== testbench/mul_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mul_defines.svh"

module mul_unit_tb
    import mul_pkg::*;
();

    localparam int NUM_VEC    = 14;
    localparam int BURST_LEN  = 20;
    localparam int MAX_ITEMS  = 32;
    localparam int WAIT_LIMIT = 500; // cycles.
    localparam int DRAIN_LEN  = 40;

    typedef struct packed {
        mul_op_t op;
        xlen_t   rs1;
        xlen_t   rs2;
        xlen_t   result;
    } vec_t;

    logic      clk;
    logic      rst_n;
    logic      req_valid;
    mul_req_t  req;
    logic      req_ready;
    logic      resp_valid;
    mul_resp_t resp;
    logic      resp_ready;

    vec_t        vec_table [NUM_VEC];
    vec_t        batch [MAX_ITEMS];
    mul_resp_t   exp_q [$]; // expected responses in issue order.
    logic [15:0] lfsr;
    tag_t        next_tag;
    int          n_accepted;
    int          n_received;
    int          peak_in_flight;

    mul_unit i_mul_unit (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .req_ready  (req_ready),
        .resp_valid (resp_valid),
        .resp       (resp),
        .resp_ready (resp_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    // sign-extend per operation, multiply in 64 bits.
    function automatic xlen_t ref_result(input mul_op_t op, input xlen_t a, input xlen_t b);
        logic [63:0] ea;
        logic [63:0] eb;
        logic [63:0] p;
        ea = {32'd0, a};
        eb = {32'd0, b};
        if (op == `MUL_OP_MULH || op == `MUL_OP_MULHSU) begin
            ea = {{32{a[31]}}, a};
        end
        if (op == `MUL_OP_MULH) begin
            eb = {{32{b[31]}}, b};
        end
        p = ea * eb;
        if (op == `MUL_OP_MUL) begin
            return p[31:0];
        end
        return p[63:32];
    endfunction

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic fail_value(input string msg);
        $display("[FAIL] %0t ns: %s", $time, msg);
        abort_run();
    endtask

    task automatic fail_timeout(input string msg);
        $display("timed out after %0d cycles: %s", WAIT_LIMIT, msg);
        abort_run();
    endtask

    task automatic check_resp(input mul_resp_t got, input mul_resp_t want, input string what);
        if (got !== want) begin
            fail_value($sformatf("%s: got result %h tag %0d, expected result %h tag %0d",
                                 what, got.result, got.tag, want.result, want.tag));
        end
    endtask

    task automatic check_ctrl(input logic got, input logic want, input string what);
        if (got !== want) begin
            fail_value($sformatf("%s: got %b, expected %b", what, got, want));
        end
    endtask

    task automatic load_table();
        vec_table[0]  = '{`MUL_OP_MUL,    32'd3,        32'd7,        32'd21};
        vec_table[1]  = '{`MUL_OP_MUL,    32'd0,        32'h12345678, 32'd0};
        vec_table[2]  = '{`MUL_OP_MUL,    32'hffffffff, 32'hffffffff, 32'd1};
        vec_table[3]  = '{`MUL_OP_MUL,    32'h00010000, 32'h00010000, 32'd0};
        vec_table[4]  = '{`MUL_OP_MUL,    32'h80000001, 32'd3,        32'h80000003};
        vec_table[5]  = '{`MUL_OP_MULHU,  32'h80000000, 32'h80000000, 32'h40000000};
        vec_table[6]  = '{`MUL_OP_MULHU,  32'hffffffff, 32'hffffffff, 32'hfffffffe};
        vec_table[7]  = '{`MUL_OP_MULH,   32'h80000000, 32'h80000000, 32'h40000000};
        vec_table[8]  = '{`MUL_OP_MULH,   32'hffffffff, 32'hffffffff, 32'd0};
        vec_table[9]  = '{`MUL_OP_MULH,   32'hffffffff, 32'd2,        32'hffffffff};
        vec_table[10] = '{`MUL_OP_MULH,   32'h7fffffff, 32'h80000000, 32'hc0000000};
        vec_table[11] = '{`MUL_OP_MULH,   32'd5,        32'hfffffffd, 32'hffffffff};
        vec_table[12] = '{`MUL_OP_MULHSU, 32'hffffffff, 32'hffffffff, 32'hffffffff};
        vec_table[13] = '{`MUL_OP_MULHSU, 32'h80000000, 32'hffffffff, 32'h80000000};
    endtask

    task automatic fill_random_batch(input int n);
        for (int i = 0; i < n; i++) begin
            batch[i].op     = mul_op_t'(take_bits(2));
            batch[i].rs1    = take_bits(32);
            batch[i].rs2    = take_bits(32);
            batch[i].result = ref_result(batch[i].op, batch[i].rs1, batch[i].rs2);
        end
    endtask

    task automatic drive_batch(input int n);
        int        wait_cycles;
        mul_resp_t want;
        for (int i = 0; i < n; i++) begin
            req_valid   = 1'b1;
            req.op      = batch[i].op;
            req.rs1     = batch[i].rs1;
            req.rs2     = batch[i].rs2;
            req.tag     = next_tag;
            want.result = batch[i].result;
            want.tag    = next_tag;
            wait_cycles = 0;
            while (!req_ready) begin
                @(posedge clk);
                #1;
                wait_cycles++;
                if (wait_cycles > WAIT_LIMIT) begin
                    fail_timeout("request was never accepted");
                end
            end
            @(posedge clk); // transfer on this edge.
            #1;
            exp_q.push_back(want);
            n_accepted++;
            if (n_accepted - n_received > peak_in_flight) begin
                peak_in_flight = n_accepted - n_received;
            end
            next_tag++;
        end
        req_valid = 1'b0;
    endtask

    task automatic collect_responses(input int n, input logic random_ready);
        int        idle_cycles;
        logic      holding;
        mul_resp_t held;
        mul_resp_t want;
        idle_cycles = 0;
        holding     = 1'b0;
        while (n_received < n) begin
            @(posedge clk);
            #1;
            resp_ready = random_ready ? (take_bits(1) != '0) : 1'b1;
            if (holding) begin
                check_ctrl(resp_valid, 1'b1, "resp_valid dropped before transfer");
                check_resp(resp, held, "response changed under back-pressure");
            end
            if (resp_valid && resp_ready) begin
                check_ctrl(exp_q.size() != 0, 1'b1, "response with nothing outstanding");
                want = exp_q.pop_front();
                check_resp(resp, want, "response");
                n_received++;
                holding     = 1'b0;
                idle_cycles = 0;
            end else if (resp_valid) begin
                holding = 1'b1;
                held    = resp;
            end
            idle_cycles++;
            if (idle_cycles > WAIT_LIMIT) begin
                fail_timeout("no response from the multiply unit");
            end
        end
    endtask

    task automatic run_batch(input int n, input logic random_ready);
        n_accepted     = 0;
        n_received     = 0;
        peak_in_flight = 0;
        fork
            drive_batch(n);
            collect_responses(n, random_ready);
        join
        // a duplicate would show up within one core run.
        for (int i = 0; i < DRAIN_LEN; i++) begin
            @(posedge clk);
            #1;
            check_ctrl(resp_valid, 1'b0, "extra response after batch");
        end
    endtask

    initial begin
        rst_n          = 1'b0;
        req_valid      = 1'b0;
        req            = '0;
        resp_ready     = 1'b0;
        lfsr           = 16'd7668;
        next_tag       = '0;
        n_accepted     = 0;
        n_received     = 0;
        peak_in_flight = 0;
        load_table();

        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_ctrl(req_ready, 1'b1, "req_ready after reset");
        check_ctrl(resp_valid, 1'b0, "resp_valid after reset");

        for (int i = 0; i < NUM_VEC; i++) begin
            batch[i] = vec_table[i];
        end
        run_batch(NUM_VEC, 1'b0);

        fill_random_batch(BURST_LEN);
        run_batch(BURST_LEN, 1'b0);
        check_ctrl(peak_in_flight > 1, 1'b1, "more than one item in flight");

        run_batch(BURST_LEN, 1'b1); // same burst, random back-pressure.

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
